/* design/cpu_params.svh */
// core build parameters
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// fetch starts here once reset is released
`define CPU_RESET_PC    32'hBFC0_0000

// datapath width
`define CPU_XLEN        32

// register file geometry
`define CPU_REG_ADDR_W  5       // index bits
`define CPU_REG_NUM     32      // entries, r0 included

`endif

/* design/cpu_pkg.sv */
// core types and stage payloads
`default_nettype none
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]       word_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,            // signed compare
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,            // value read in ID
        FWD_MEM,            // ALU result sitting in MEM
        FWD_WB              // final WB result
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;      // ALU b from immediate
        logic     zero_ext;     // immediate is zero-extended
        logic     reg_write;
        logic     load;
        logic     store;
        logic     branch_eq;
        logic     branch_ne;
        reg_idx_t dst;
    } ctrl_s;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } if_id_s;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        ctrl_s    ctrl;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
    } id_ex_s;

    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_s ctrl;
        word_t alu_res;         // also the data address
        word_t store_data;
    } ex_mem_s;

    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_s ctrl;
        word_t alu_res;
    } mem_wb_s;

endpackage

`default_nettype wire

/* design/control_unit.sv */
// instruction decoder
`timescale 1ns/1ps
`default_nettype none

module control_unit import cpu_pkg::*; (
    input  word_t instr_i,
    output ctrl_s ctrl_o,
    output word_t imm_o
);

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    localparam logic [5:0] FN_ADDU    = 6'b100001;
    localparam logic [5:0] FN_SUBU    = 6'b100011;
    localparam logic [5:0] FN_AND     = 6'b100100;
    localparam logic [5:0] FN_OR      = 6'b100101;
    localparam logic [5:0] FN_SLT     = 6'b101010;

    logic [5:0] opcode;
    logic [5:0] funct;
    ctrl_s      ctrl;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    always_comb begin
        ctrl = '0;                              // anything unknown is a no-op
        case (opcode)
            OP_SPECIAL: begin
                ctrl.dst       = instr_i[15:11];    // rd
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                ctrl.dst       = instr_i[20:16];    // rt
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.load      = (opcode == OP_LW);
                ctrl.zero_ext  = (opcode == OP_ORI);
                if (opcode == OP_ORI) ctrl.alu_op = ALU_OR;
                if (opcode == OP_LUI) ctrl.alu_op = ALU_LUI;
            end
            OP_SW: begin
                ctrl.use_imm = 1'b1;                // address = rs + offset
                ctrl.store   = 1'b1;
            end
            OP_BEQ:  ctrl.branch_eq = 1'b1;
            OP_BNE:  ctrl.branch_ne = 1'b1;
            default: ;
        endcase
        if (ctrl.dst == '0) ctrl.reg_write = 1'b0;  // r0 is never written
    end

    assign ctrl_o = ctrl;
    assign imm_o  = ctrl.zero_ext ? {16'b0, instr_i[15:0]}
                                  : {{16{instr_i[15]}}, instr_i[15:0]};

endmodule

`default_nettype wire

/* design/reg_file.sv */
// general purpose register file
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module reg_file import cpu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       we_i,
    input  logic [`CPU_REG_ADDR_W-1:0] waddr_i,
    input  word_t                      wdata_i,
    input  logic [`CPU_REG_ADDR_W-1:0] raddr_a_i,
    input  logic [`CPU_REG_ADDR_W-1:0] raddr_b_i,
    output word_t                      rdata_a_o,
    output word_t                      rdata_b_o
);

    word_t regs_q [`CPU_REG_NUM];

    // same-cycle write wins so ID never sees a stale WB value
    function automatic word_t read_reg(input logic [`CPU_REG_ADDR_W-1:0] addr);
        if (addr == '0) return '0;
        if (we_i && (waddr_i == addr)) return wdata_i;
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CPU_REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata_a_o = read_reg(raddr_a_i);
        rdata_b_o = read_reg(raddr_b_i);
    end

endmodule

`default_nettype wire

/* design/alu.sv */
// integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o
);

    logic less;

    assign less = $signed(a_i) < $signed(b_i);

    always_comb begin
        unique case (op_i)
            ALU_ADD: result_o = a_i + b_i;          // also load/store address
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = {31'b0, less};
            ALU_LUI: result_o = {b_i[15:0], 16'b0}; // immediate into upper half
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
// forwarding, stall and flush control
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module hazard_unit import cpu_pkg::*; (
    input  logic [`CPU_REG_ADDR_W-1:0] id_rs_i,
    input  logic [`CPU_REG_ADDR_W-1:0] id_rt_i,
    input  id_ex_s                     ex_i,
    input  ex_mem_s                    mem_i,
    input  mem_wb_s                    wb_i,
    input  logic                       branch_taken_i,
    output fwd_sel_e                   fwd_a_o,
    output fwd_sel_e                   fwd_b_o,
    output logic                       stall_o,
    output logic                       flush_o
);

    logic mem_fwd_ok;   // MEM holds an ALU result worth forwarding
    logic wb_fwd_ok;
    logic ex_load;

    assign mem_fwd_ok = mem_i.valid && mem_i.ctrl.reg_write && !mem_i.ctrl.load;
    assign wb_fwd_ok  = wb_i.valid && wb_i.ctrl.reg_write;
    assign ex_load    = ex_i.valid && ex_i.ctrl.load && ex_i.ctrl.reg_write;

    function automatic fwd_sel_e pick(input reg_idx_t src);
        if (src == '0) return FWD_REG;
        if (mem_fwd_ok && (mem_i.ctrl.dst == src)) return FWD_MEM;   // youngest first
        if (wb_fwd_ok && (wb_i.ctrl.dst == src)) return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a_o = pick(ex_i.rs);
        fwd_b_o = pick(ex_i.rt);
    end

    // load data only exists in WB so a consumer right behind waits a cycle
    assign stall_o = ex_load && ((ex_i.ctrl.dst == id_rs_i) || (ex_i.ctrl.dst == id_rt_i));
    assign flush_o = branch_taken_i;        // squash the fetch after the delay slot

endmodule

`default_nettype wire

/* design/pipe_reg.sv */
// pipeline stage register
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic    // stage struct, valid bit included
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     stall_i,           // keep current contents
    input  logic     flush_i,           // load a bubble
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* design/mycpu_top.sv */
// five-stage MIPS integer core
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module mycpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    output logic       inst_sram_en_o,
    output word_t      inst_sram_addr_o,
    input  word_t      inst_sram_rdata_i,
    output logic       data_sram_en_o,
    output logic [3:0] data_sram_wen_o,
    output word_t      data_sram_addr_o,
    output word_t      data_sram_wdata_o,
    input  word_t      data_sram_rdata_i,
    output word_t      debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output reg_idx_t   debug_wb_rf_wnum_o,
    output word_t      debug_wb_rf_wdata_o
);

    localparam logic [5:0] OP_J = 6'b000010;

    word_t    pc_q, pc_next, jump_target, branch_target;
    logic     fetch_on_q;
    if_id_s   if_d, if_q;
    id_ex_s   id_d, ex_q;
    ex_mem_s  ex_d, mem_q;
    mem_wb_s  mem_d, wb_q;
    word_t    id_instr, id_imm, id_rs_val, id_rt_val;
    ctrl_s    id_ctrl;
    logic     id_jump, stall, flush, branch_taken, wb_we;
    fwd_sel_e fwd_a, fwd_b;
    word_t    ex_a, ex_b, alu_b, alu_res, wb_result;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t rf_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    // IF: branch in EXE outranks the jump sitting in its delay slot
    always_comb begin
        pc_next = pc_q + 32'd4;
        if (branch_taken) pc_next = branch_target;
        else if (id_jump) pc_next = jump_target;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= `CPU_RESET_PC;
            fetch_on_q <= 1'b0;
        end else begin
            fetch_on_q <= 1'b1;
            if (fetch_on_q && !stall) pc_q <= pc_next;
        end
    end

    assign inst_sram_en_o   = fetch_on_q & ~stall;  // SRAM output holds during stall
    assign inst_sram_addr_o = pc_q;
    assign if_d             = '{valid: fetch_on_q, pc: pc_q};

    pipe_reg #(.payload_t(if_id_s)) u_if_id (
        .clk, .rst_n_i, .stall_i(stall), .flush_i(flush), .d_i(if_d), .q_o(if_q)
    );

    // ID: instruction word arrives straight from the SRAM
    assign id_instr    = if_q.valid ? inst_sram_rdata_i : '0;
    assign id_jump     = if_q.valid && (id_instr[31:26] == OP_J);
    assign jump_target = {if_q.pc[31:28], id_instr[25:0], 2'b00};

    control_unit u_ctrl (.instr_i(id_instr), .ctrl_o(id_ctrl), .imm_o(id_imm));

    reg_file u_rf (
        .clk, .rst_n_i,
        .we_i(wb_we), .waddr_i(wb_q.ctrl.dst), .wdata_i(wb_result),
        .raddr_a_i(id_instr[25:21]), .raddr_b_i(id_instr[20:16]),
        .rdata_a_o(id_rs_val), .rdata_b_o(id_rt_val)
    );

    hazard_unit u_hazard (
        .id_rs_i(id_instr[25:21]), .id_rt_i(id_instr[20:16]),
        .ex_i(ex_q), .mem_i(mem_q), .wb_i(wb_q), .branch_taken_i(branch_taken),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall), .flush_o(flush)
    );

    assign id_d = '{valid: if_q.valid, pc: if_q.pc, ctrl: id_ctrl,
                    rs: id_instr[25:21], rt: id_instr[20:16],
                    rs_val: id_rs_val, rt_val: id_rt_val, imm: id_imm};

    pipe_reg #(.payload_t(id_ex_s)) u_id_ex (
        .clk, .rst_n_i, .stall_i(1'b0), .flush_i(stall), .d_i(id_d), .q_o(ex_q)
    );

    // EXE
    assign ex_a  = fwd_mux(fwd_a, ex_q.rs_val, mem_q.alu_res, wb_result);
    assign ex_b  = fwd_mux(fwd_b, ex_q.rt_val, mem_q.alu_res, wb_result);
    assign alu_b = ex_q.ctrl.use_imm ? ex_q.imm : ex_b;

    alu u_alu (.op_i(ex_q.ctrl.alu_op), .a_i(ex_a), .b_i(alu_b), .result_o(alu_res));

    assign branch_taken  = ex_q.valid && ((ex_q.ctrl.branch_eq && (ex_a == ex_b)) ||
                                          (ex_q.ctrl.branch_ne && (ex_a != ex_b)));
    assign branch_target = ex_q.pc + 32'd4 + {ex_q.imm[29:0], 2'b00};
    assign ex_d = '{valid: ex_q.valid, pc: ex_q.pc, ctrl: ex_q.ctrl,
                    alu_res: alu_res, store_data: ex_b};

    pipe_reg #(.payload_t(ex_mem_s)) u_ex_mem (
        .clk, .rst_n_i, .stall_i(1'b0), .flush_i(1'b0), .d_i(ex_d), .q_o(mem_q)
    );

    // MEM: word accesses only
    assign data_sram_en_o    = mem_q.valid && (mem_q.ctrl.load || mem_q.ctrl.store);
    assign data_sram_wen_o   = {4{mem_q.valid && mem_q.ctrl.store}};
    assign data_sram_addr_o  = mem_q.alu_res;
    assign data_sram_wdata_o = mem_q.store_data;
    assign mem_d = '{valid: mem_q.valid, pc: mem_q.pc, ctrl: mem_q.ctrl, alu_res: mem_q.alu_res};

    pipe_reg #(.payload_t(mem_wb_s)) u_mem_wb (
        .clk, .rst_n_i, .stall_i(1'b0), .flush_i(1'b0), .d_i(mem_d), .q_o(wb_q)
    );

    // WB: load data shows up here, one cycle after the MEM access
    assign wb_result = wb_q.ctrl.load ? data_sram_rdata_i : wb_q.alu_res;
    assign wb_we     = wb_q.valid && wb_q.ctrl.reg_write;

    assign debug_wb_pc_o       = wb_q.pc;
    assign debug_wb_rf_wen_o   = {4{wb_we}};
    assign debug_wb_rf_wnum_o  = wb_q.ctrl.dst;
    assign debug_wb_rf_wdata_o = wb_result;

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;         // 20 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_n_o <= 1'b1;                    // release on a rising edge
    end

endmodule

`default_nettype wire

/* test/cpu_properties.sv */
// core interface assertions
`timescale 1ns/1ps
`default_nettype none

module cpu_properties import cpu_pkg::*; (
    input logic       clk,
    input logic       rst_n_i,
    input logic       inst_sram_en_i,
    input logic       data_sram_en_i,
    input logic [3:0] data_sram_wen_i,
    input logic [3:0] debug_wb_rf_wen_i,
    input reg_idx_t   debug_wb_rf_wnum_i
);

    int assert_fails = 0;

    no_r0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        (debug_wb_rf_wen_i != 4'b0) |-> (debug_wb_rf_wnum_i != '0))
        else begin
            assert_fails++;
            $error("debug port reports a write to register 0");
        end

    wen_needs_en: assert property (@(posedge clk) disable iff (!rst_n_i)
        (data_sram_wen_i != 4'b0) |-> data_sram_en_i)
        else begin
            assert_fails++;
            $error("data SRAM write enable set without the enable");
        end

    // no fetch while the core is held in reset
    quiet_fetch_in_reset: assert property (@(posedge clk) !rst_n_i |-> !inst_sram_en_i)
        else begin
            assert_fails++;
            $error("instruction fetch enabled during reset");
        end

endmodule

bind mycpu_top cpu_properties u_props (
    .clk(clk),
    .rst_n_i(rst_n_i),
    .inst_sram_en_i(inst_sram_en_o),
    .data_sram_en_i(data_sram_en_o),
    .data_sram_wen_i(data_sram_wen_o),
    .debug_wb_rf_wen_i(debug_wb_rf_wen_o),
    .debug_wb_rf_wnum_i(debug_wb_rf_wnum_o)
);

`default_nettype wire

/* test/cpu_tb.sv */
// core testbench with reference model
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int MEM_WORDS = 1024;
    localparam int BODY_LEN  = 200;
    localparam int SEED      = 90;

    localparam logic [5:0] OP_SPECIAL = 6'd0;
    localparam logic [5:0] OP_J       = 6'd2;
    localparam logic [5:0] OP_BEQ     = 6'd4;
    localparam logic [5:0] OP_BNE     = 6'd5;
    localparam logic [5:0] OP_ADDIU   = 6'd9;
    localparam logic [5:0] OP_ORI     = 6'd13;
    localparam logic [5:0] OP_LUI     = 6'd15;
    localparam logic [5:0] OP_LW      = 6'd35;
    localparam logic [5:0] OP_SW      = 6'd43;
    localparam logic [5:0] FN_ADDU    = 6'd33;
    localparam logic [5:0] FN_SUBU    = 6'd35;
    localparam logic [5:0] FN_AND     = 6'd36;
    localparam logic [5:0] FN_OR      = 6'd37;
    localparam logic [5:0] FN_SLT     = 6'd42;

    typedef struct packed {
        word_t    pc;
        reg_idx_t num;
        word_t    data;
    } retire_rec_s;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_rec_s;

    logic        clk;
    logic        rst_n;
    logic        inst_en;
    word_t       inst_addr;
    word_t       inst_rdata;
    logic        data_en;
    logic [3:0]  data_wen;
    word_t       data_addr;
    word_t       data_wdata;
    word_t       data_rdata;
    word_t       wb_pc;
    logic [3:0]  wb_wen;
    reg_idx_t    wb_num;
    word_t       wb_data;

    word_t       imem [MEM_WORDS];
    word_t       dmem [MEM_WORDS];
    retire_rec_s retire_q [$];
    store_rec_s  store_q [$];
    word_t       load_q [$];
    int          prog_len;
    int          exec_count;
    word_t       halt_pc;

    tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    mycpu_top dut_i (
        .clk(clk), .rst_n_i(rst_n),
        .inst_sram_en_o(inst_en), .inst_sram_addr_o(inst_addr),
        .inst_sram_rdata_i(inst_rdata),
        .data_sram_en_o(data_en), .data_sram_wen_o(data_wen),
        .data_sram_addr_o(data_addr), .data_sram_wdata_o(data_wdata),
        .data_sram_rdata_i(data_rdata),
        .debug_wb_pc_o(wb_pc), .debug_wb_rf_wen_o(wb_wen),
        .debug_wb_rf_wnum_o(wb_num), .debug_wb_rf_wdata_o(wb_data)
    );

    function automatic int word_index(input word_t addr);
        return int'(addr[11:2]);                // both SRAMs are 4 KB windows
    endfunction

    function automatic word_t fill_word(input int idx);
        return (word_t'(idx) * 32'h9E37_79B9) ^ 32'hC0DE_0000;
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input reg_idx_t rs,
                                    input reg_idx_t rt, input reg_idx_t rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input reg_idx_t rs,
                                    input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(input word_t target);
        return {OP_J, target[27:2]};
    endfunction

    function automatic word_t pc_of(input int idx);
        return `CPU_RESET_PC + word_t'(4 * idx);
    endfunction

    function automatic logic [5:0] random_funct();
        case ($urandom_range(0, 4))
            0:       return FN_ADDU;
            1:       return FN_SUBU;
            2:       return FN_AND;
            3:       return FN_OR;
            default: return FN_SLT;
        endcase
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic add_directed_prefix();
        emit(enc_i(OP_ADDIU, 5'd0, 5'd1, 16'd5));
        emit(enc_i(OP_ADDIU, 5'd1, 5'd2, 16'd3));      // MEM forward
        emit(enc_r(FN_ADDU, 5'd1, 5'd2, 5'd3));        // WB and MEM forward
        emit(enc_r(FN_SUBU, 5'd3, 5'd1, 5'd4));
        emit(enc_i(OP_LUI, 5'd0, 5'd5, 16'h1234));
        emit(enc_i(OP_ORI, 5'd5, 5'd5, 16'h5678));
        emit(enc_i(OP_SW, 5'd0, 5'd5, 16'd16));
        emit(enc_i(OP_LW, 5'd0, 5'd6, 16'd16));
        emit(enc_r(FN_ADDU, 5'd6, 5'd6, 5'd7));        // load-use
        emit(enc_r(FN_SLT, 5'd4, 5'd7, 5'd1));
        emit(enc_r(FN_AND, 5'd7, 5'd5, 5'd2));
        emit(enc_i(OP_BEQ, 5'd1, 5'd1, 16'd2));        // always taken
        emit(enc_r(FN_OR, 5'd2, 5'd4, 5'd3));          // delay slot
        emit(enc_i(OP_ADDIU, 5'd0, 5'd3, 16'h07ff));   // skipped
        emit(enc_i(OP_BNE, 5'd1, 5'd1, 16'd5));        // never taken
        emit(enc_i(OP_ADDIU, 5'd4, 5'd4, 16'd1));
        emit(enc_j(pc_of(prog_len + 3)));
        emit(enc_i(OP_ADDIU, 5'd0, 5'd6, 16'd9));      // jump delay slot
        emit(enc_i(OP_ADDIU, 5'd0, 5'd6, 16'h0055));   // skipped
        emit(enc_i(OP_LW, 5'd0, 5'd2, 16'd16));
        emit(enc_i(OP_BNE, 5'd2, 5'd0, 16'd2));        // load feeds branch
        emit(enc_r(FN_SUBU, 5'd2, 5'd6, 5'd7));
        emit(enc_i(OP_ADDIU, 5'd0, 5'd7, 16'd1));      // skipped
        emit(enc_i(OP_SW, 5'd0, 5'd7, 16'd20));
        emit(enc_i(OP_LW, 5'd0, 5'd1, 16'd20));
    endtask

    task automatic add_random_body();
        int          last_idx;
        int          off;
        int          kind;
        logic        after_branch;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [15:0] imm;
        last_idx     = prog_len + BODY_LEN;             // index of the final J
        after_branch = 1'b0;
        for (int i = 0; i < BODY_LEN; i++) begin
            rs   = reg_idx_t'($urandom_range(0, 7));
            rt   = reg_idx_t'($urandom_range(0, 7));
            rd   = reg_idx_t'($urandom_range(0, 7));
            imm  = 16'($urandom());
            off  = int'($urandom_range(1, 4));
            kind = after_branch ? 0 : int'($urandom_range(0, 9));
            after_branch = 1'b0;
            case (kind)
                0:       emit(enc_r(random_funct(), rs, rt, rd));
                1:       emit(enc_i(OP_ADDIU, rs, rt, imm));
                2:       emit(enc_i(OP_ORI, rs, rt, imm));
                3:       emit(enc_i(OP_LUI, 5'd0, rt, imm));
                4, 5:    emit(enc_i(OP_LW, 5'd0, rt, 16'(4 * $urandom_range(0, 63))));
                6:       emit(enc_i(OP_SW, 5'd0, rt, 16'(4 * $urandom_range(0, 63))));
                7, 8: begin
                    if ((i < BODY_LEN - 1) && (prog_len + 1 + off <= last_idx)) begin
                        emit(enc_i(kind == 7 ? OP_BEQ : OP_BNE, rs, rt, 16'(off)));
                        after_branch = 1'b1;                // next one is the delay slot
                    end else begin
                        emit(enc_r(FN_ADDU, rs, rt, rd));
                    end
                end
                default: emit({6'h3f, 26'($urandom())});   // undefined opcode
            endcase
        end
        halt_pc = pc_of(prog_len);
        emit(enc_j(halt_pc));                           // spin here
        emit(32'h0);
    endtask

    // sequential ISA model with one delay slot
    function automatic int ref_run();
        word_t       regs [32];
        word_t       mem [MEM_WORDS];
        word_t       pc;
        word_t       npc;
        word_t       nxt;
        word_t       ins;
        word_t       a;
        word_t       b;
        word_t       imm_s;
        word_t       res;
        reg_idx_t    dst;
        logic        wr;
        int          count;
        retire_rec_s r_rec;
        store_rec_s  s_rec;
        regs = '{default: '0};
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        pc    = `CPU_RESET_PC;
        npc   = pc + 32'd4;
        count = 0;
        while ((pc != halt_pc) && (count < 10000)) begin
            ins   = imem[word_index(pc)];
            a     = regs[ins[25:21]];
            b     = regs[ins[20:16]];
            imm_s = {{16{ins[15]}}, ins[15:0]};
            dst   = ins[20:16];
            wr    = ins[31:26] inside {OP_ADDIU, OP_ORI, OP_LUI, OP_LW};
            res   = '0;
            nxt   = npc + 32'd4;
            case (ins[31:26])
                OP_SPECIAL: begin
                    dst = ins[15:11];
                    wr  = 1'b1;
                    case (ins[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + imm_s;
                OP_ORI:   res = a | {16'd0, ins[15:0]};
                OP_LUI:   res = {ins[15:0], 16'd0};
                OP_LW: begin
                    res = mem[word_index(a + imm_s)];
                    load_q.push_back(a + imm_s);
                end
                OP_SW: begin
                    mem[word_index(a + imm_s)] = b;
                    s_rec = '{addr: a + imm_s, data: b};
                    store_q.push_back(s_rec);
                end
                OP_BEQ:   if (a == b) nxt = pc + 32'd4 + {imm_s[29:0], 2'b00};
                OP_BNE:   if (a != b) nxt = pc + 32'd4 + {imm_s[29:0], 2'b00};
                OP_J:     nxt = {pc[31:28], ins[25:0], 2'b00};
                default:  ;
            endcase
            if (wr && (dst != '0)) begin
                regs[dst] = res;
                r_rec = '{pc: pc, num: dst, data: res};
                retire_q.push_back(r_rec);
            end
            pc  = npc;
            npc = nxt;
            count++;
        end
        return count;
    endfunction

    task automatic end_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_retire(input word_t pc, input reg_idx_t num, input word_t data);
        retire_rec_s exp;
        if (retire_q.size() == 0) begin
            $display("register write at %0t has no matching write in the reference", $time);
            end_with_failure();
        end else begin
            exp = retire_q.pop_front();
            if (pc !== exp.pc) begin
                $display("MISMATCH at %0t: debug_wb_pc_o got %h expected %h", $time, pc, exp.pc);
                end_with_failure();
            end
            if (num !== exp.num) begin
                $display("MISMATCH at %0t: debug_wb_rf_wnum_o got %0d expected %0d",
                         $time, num, exp.num);
                end_with_failure();
            end
            if (data !== exp.data) begin
                $display("MISMATCH at %0t: debug_wb_rf_wdata_o got %h expected %h",
                         $time, data, exp.data);
                end_with_failure();
            end
        end
    endtask

    task automatic compare_store(input word_t addr, input word_t data);
        store_rec_s exp;
        if (store_q.size() == 0) begin
            $display("data SRAM write at %0t has no matching store in the reference", $time);
            end_with_failure();
        end else begin
            exp = store_q.pop_front();
            if (addr !== exp.addr) begin
                $display("MISMATCH at %0t: data_sram_addr_o got %h expected %h",
                         $time, addr, exp.addr);
                end_with_failure();
            end
            if (data !== exp.data) begin
                $display("MISMATCH at %0t: data_sram_wdata_o got %h expected %h",
                         $time, data, exp.data);
                end_with_failure();
            end
        end
    endtask

    task automatic compare_load(input word_t addr);
        word_t exp;
        if (load_q.size() == 0) begin
            $display("data SRAM read at %0t has no matching load in the reference", $time);
            end_with_failure();
        end else begin
            exp = load_q.pop_front();
            if (addr !== exp) begin
                $display("MISMATCH at %0t: data_sram_addr_o got %h expected %h",
                         $time, addr, exp);
                end_with_failure();
            end
        end
    endtask

    // SRAM models with one cycle read latency
    always @(posedge clk) begin
        if (inst_en) inst_rdata <= imem[word_index(inst_addr)];
    end

    always @(posedge clk) begin
        if (data_en) begin
            if (data_wen != 4'b0) dmem[word_index(data_addr)] <= data_wdata;
            data_rdata <= dmem[word_index(data_addr)];     // old word on a store
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (dut_i.u_props.assert_fails != 0) begin
                $display("a bound assertion on the core failed");
                end_with_failure();
            end
            if (wb_wen != 4'b0) compare_retire(wb_pc, wb_num, wb_data);
            if (data_wen != 4'b0) compare_store(data_addr, data_wdata);
            if (data_en && (data_wen == 4'b0)) compare_load(data_addr);
        end
    end

    initial begin
        @(posedge rst_n);
        repeat (3 * exec_count + 100) @(posedge clk);
        $display("timeout after %0d cycles with %0d writes, %0d stores and %0d loads pending",
                 3 * exec_count + 100, retire_q.size(), store_q.size(), load_q.size());
        end_with_failure();
    end

    initial begin
        void'($urandom(SEED));
        inst_rdata = '0;
        data_rdata = '0;
        prog_len   = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(i);
        end
        add_directed_prefix();
        add_random_body();
        exec_count = ref_run();
        @(posedge rst_n);
        while ((retire_q.size() != 0) || (store_q.size() != 0) || (load_q.size() != 0)) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);                 // core spins on the final J
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/cpu_pkg.sv
design/control_unit.sv
design/reg_file.sv
design/alu.sv
design/hazard_unit.sv
design/pipe_reg.sv
design/mycpu_top.sv
test/tb_clock_gen.sv
test/cpu_properties.sv
test/cpu_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := cpu_tb
FILELIST  := verilog.f
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
